/* bench/edge_fetch_golden.txt */
# dest lo_half hi_half expected, all hex; word 0 is the low 32 bits of lo_half
# expected is the word at dest modulo 4 with its four bytes swapped
00000010 01015ac101005ac0 01035ac301025ac2 c05a0001
00000021 02015ac102005ac0 02035ac302025ac2 c15a0102
00000032 03015ac103005ac0 03035ac303025ac2 c25a0203
00000043 04015ac104005ac0 04035ac304025ac2 c35a0304
00000104 05015ac105005ac0 05035ac305025ac2 c05a0005
00000155 06015ac106005ac0 06035ac306025ac2 c15a0106
000001a6 07015ac107005ac0 07035ac307025ac2 c25a0207
000001f7 08015ac108005ac0 08035ac308025ac2 c35a0308
00002008 09015ac109005ac0 09035ac309025ac2 c05a0009
00002019 0a015ac10a005ac0 0a035ac30a025ac2 c15a010a
0000302a 0b015ac10b005ac0 0b035ac30b025ac2 c25a020b
0000403b 0c015ac10c005ac0 0c035ac30c025ac2 c35a030c
0000504c 0d015ac10d005ac0 0d035ac30d025ac2 c05a000d
0000605d 0e015ac10e005ac0 0e035ac30e025ac2 c15a010e
0000706e 0f015ac10f005ac0 0f035ac30f025ac2 c25a020f
0000807f 10015ac110005ac0 10035ac310025ac2 c35a0310
00009090 11015ac111005ac0 11035ac311025ac2 c05a0011
0000a0a1 12015ac112005ac0 12035ac312025ac2 c15a0112
0000b0b2 13015ac113005ac0 13035ac313025ac2 c25a0213
0000c0c3 14015ac114005ac0 14035ac314025ac2 c35a0314
0001d0d4 15015ac115005ac0 15035ac315025ac2 c05a0015
0001e0e5 16015ac116005ac0 16035ac316025ac2 c15a0116
0001f0f6 17015ac117005ac0 17035ac317025ac2 c25a0217
00020107 18015ac118005ac0 18035ac318025ac2 c35a0318
00030218 19015ac119005ac0 19035ac319025ac2 c05a0019
0004032b 1a015ac11a005ac0 1a035ac31a025ac2 c35a031a

/* bench/edge_fetch_sva.sv */
////////////////////////////////////////
// bound into edge_data_control; enable is
// never cleared while a command can issue
////////////////////////////////////////

`timescale 1ns/1ps

module edge_fetch_sva
	import edge_fetch_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input logic       clock,
	input logic       rstn,
	input cu_config_t cfg,
	input cu_status_t status,
	input read_cmd_t  read_cmd,
	input line_half_t line_lo,
	input line_half_t line_hi,
	input logic       edge_pop,
	input edge_data_t edge_data
);

	int fail_count = 0;

	outstanding_bound: assert property (@(posedge clock) disable iff (!rstn)
		status.outstanding <= 8'(FIFO_DEPTH))
		else begin
			$error("outstanding reads above the queue depth");
			fail_count++;
		end

	no_cmd_when_disabled: assert property (@(posedge clock) disable iff (!rstn)
		!(read_cmd.valid && !cfg.enable))
		else begin
			$error("read command issued while disabled");
			fail_count++;
		end

	// both halves of a line arrive in one cycle
	halves_together: assert property (@(posedge clock) disable iff (!rstn)
		line_lo.valid == line_hi.valid)
		else begin
			$error("line halves not valid together");
			fail_count++;
		end

	data_after_pop: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid |-> $past(edge_pop))
		else begin
			$error("edge data valid without a pop one cycle earlier");
			fail_count++;
		end

endmodule

/* bench/tb_edge_fetch.sv */
////////////////////////////////////////
// run from the project root so the golden
// file path resolves; needs 26+ records
////////////////////////////////////////

`timescale 1ns/1ps

module tb_edge_fetch
	import edge_fetch_pkg::*;
;

	localparam int          CU_ID      = 3;
	localparam int          FIFO_DEPTH = 8;
	localparam logic [31:0] BASE_ADDR  = 32'h8000_1000;
	localparam logic [31:0] DEGREE     = 32'd5;

	logic        clock;
	logic        rstn;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	edge_job_t   edge_job;
	vertex_job_t vertex_job;
	logic        edge_request;
	read_cmd_t   read_cmd;
	logic        cmd_ready;
	logic        read_response;
	line_half_t  line_lo;
	line_half_t  line_hi;
	logic        edge_data_request;
	edge_data_t  edge_data;

	// golden records
	logic [31:0] rec_dest [64];
	logic [63:0] rec_lo [64];
	logic [63:0] rec_hi [64];
	logic [31:0] rec_exp [64];
	logic        rec_shared [64];
	int          n_rec = 0;

	int          rsp_rec_q [$];
	logic [WORD_INDEX_BITS-1:0] rsp_off_q [$];
	logic [31:0] lcg_state = 32'h0e224064;
	int          ready_mode = 0;
	int          req_mode = 0;
	int          cmd_seen = 0;
	int          rx_count = 0;
	int          cycles = 0;
	int          limit = 500;
	int          errors = 0;
	int          total_checks = 0;
	int          test_checks = 0;
	int          test_errs = 0;
	int          tests_run = 0;

	edge_fetch_top #(.CU_ID(CU_ID), .FIFO_DEPTH(FIFO_DEPTH)) dut (
		.clock             (clock),
		.rstn              (rstn),
		.apb_req           (apb_req),
		.apb_rsp           (apb_rsp),
		.edge_job          (edge_job),
		.vertex_job        (vertex_job),
		.edge_request      (edge_request),
		.read_cmd          (read_cmd),
		.cmd_ready         (cmd_ready),
		.read_response     (read_response),
		.line_lo           (line_lo),
		.line_hi           (line_hi),
		.edge_data_request (edge_data_request),
		.edge_data         (edge_data)
	);

	bind edge_data_control edge_fetch_sva #(.FIFO_DEPTH(FIFO_DEPTH)) u_sva (
		.clock     (clock),
		.rstn      (rstn),
		.cfg       (cfg),
		.status    (status),
		.read_cmd  (read_cmd),
		.line_lo   (line_lo),
		.line_hi   (line_hi),
		.edge_pop  (edge_pop),
		.edge_data (edge_data)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, the data path stalled", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		total_checks++;
		test_checks++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %-20s checks %0d errors %0d", name, test_checks, test_errs);
		tests_run++;
		test_checks = 0;
		test_errs = 0;
	endtask

////////////////////////////////////////
// bus and job drivers
////////////////////////////////////////

	task automatic apb_xfer(input logic write, input logic [11:0] addr,
	                        input logic [31:0] wdata, output logic [31:0] rdata,
	                        output logic err);
		@(posedge clock);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clock);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clock);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		check("apb pready", 32'(apb_rsp.pready), 32'd1);
		@(posedge clock);
		#1;
		apb_req = '0;
	endtask

	// one job per cycle while edge_request was seen high
	task automatic feed_jobs(input int first, input int count, input logic shared);
		int i;
		i = first;
		while (i < first + count) begin
			@(posedge clock);
			#1;
			if (edge_request) begin
				rec_shared[i] = shared;
				edge_job = '{valid: 1'b1, dest: rec_dest[i], src: 32'(i)};
				i++;
			end else begin
				edge_job = '0;
			end
		end
		@(posedge clock);
		#1;
		edge_job = '0;
	endtask

	task automatic wait_words(input int target);
		while (rx_count < target)
			@(posedge clock);
	endtask

////////////////////////////////////////
// memory model and handshake drive
////////////////////////////////////////

	initial begin : mem_drive
		logic [31:0]                r;
		int                         rec;
		int                         resp_wait;
		logic                       armed;
		logic [WORD_INDEX_BITS-1:0] off;
		armed = 1'b0;
		resp_wait = 0;
		forever begin
			@(posedge clock);
			#1;
			r = lcg_next();
			case (ready_mode)
				0:       cmd_ready = 1'b1;
				1:       cmd_ready = r[21];
				default: cmd_ready = 1'b0;
			endcase
			edge_data_request = (req_mode == 0) ? 1'b1 : r[26];
			read_response = 1'b0;
			line_lo = '0;
			line_hi = '0;
			if (!armed && rsp_rec_q.size() > 0) begin
				resp_wait = 1 + int'((lcg_next() >> 16) % 32'd6);
				armed = 1'b1;
			end
			if (armed) begin
				resp_wait--;
				if (resp_wait == 0) begin
					rec = rsp_rec_q.pop_front();
					off = rsp_off_q.pop_front();
					line_lo = '{valid: 1'b1, offset: off, data: rec_lo[rec]};
					line_hi = '{valid: 1'b1, offset: off, data: rec_hi[rec]};
					read_response = 1'b1;
					armed = 1'b0;
				end
			end
		end
	end

	// commands and edge data, sampled mid-cycle
	always @(negedge clock) begin : monitor
		int j;
		if (read_cmd.valid) begin
			j = cmd_seen;
			cmd_seen++;
			if (j >= n_rec) begin
				$display("read command at %0t beyond the last record", $time);
				errors++;
				test_errs++;
			end else begin
				check("cmd address", read_cmd.address, BASE_ADDR + (rec_dest[j] << 2));
				check("cmd offset", 32'(read_cmd.offset), rec_dest[j] % 32'd4);
				check("cmd kind", 32'(read_cmd.kind),
				      rec_shared[j] ? 32'(read_cl_s) : 32'(read_cl_na));
				check("cmd cu id", 32'(read_cmd.cu_id), 32'(CU_ID));
				// one 32-bit data word per command
				check("cmd size", 32'(read_cmd.size), 32'd4);
				rsp_rec_q.push_back(j);
				rsp_off_q.push_back(read_cmd.offset);
			end
		end
		if (edge_data.valid) begin
			if (rx_count >= n_rec) begin
				$display("extra edge data word at %0t", $time);
				errors++;
				test_errs++;
			end else begin
				check("edge data", edge_data.data, rec_exp[rx_count]);
			end
			rx_count++;
		end
	end

////////////////////////////////////////
// test sequence
////////////////////////////////////////

	initial begin : main
		int          fd;
		string       line;
		logic [31:0] d;
		logic [63:0] lo;
		logic [63:0] hi;
		logic [31:0] ex;
		logic [31:0] rdata;
		logic        err;
		int          held;
		int          cmds_before;
		rstn = 1'b0;
		apb_req = '0;
		edge_job = '0;
		vertex_job = '0;
		cmd_ready = 1'b0;
		read_response = 1'b0;
		line_lo = '0;
		line_hi = '0;
		edge_data_request = 1'b0;
		fd = $fopen("bench/edge_fetch_golden.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 0 && line[0] != "#" && n_rec < 64 &&
				    $sscanf(line, "%h %h %h %h", d, lo, hi, ex) == 4) begin
					rec_dest[n_rec] = d;
					rec_lo[n_rec]   = lo;
					rec_hi[n_rec]   = hi;
					rec_exp[n_rec]  = ex;
					n_rec++;
				end
			end
			$fclose(fd);
		end
		limit = 200 * n_rec + 500;
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		if (n_rec < 26) begin
			$display("golden file missing or holding fewer than 26 records");
			errors++;
		end else begin
			apb_xfer(1'b1, REG_BASE, BASE_ADDR, rdata, err);
			check("base write error", 32'(err), 32'd0);
			apb_xfer(1'b0, REG_BASE, 32'd0, rdata, err);
			check("base readback", rdata, BASE_ADDR);
			apb_xfer(1'b1, REG_DEGREE, DEGREE, rdata, err);
			apb_xfer(1'b0, REG_DEGREE, 32'd0, rdata, err);
			check("degree readback", rdata, DEGREE);
			apb_xfer(1'b1, REG_CTRL, 32'h2, rdata, err);
			apb_xfer(1'b0, REG_CTRL, 32'd0, rdata, err);
			check("ctrl readback", rdata, 32'h2);
			apb_xfer(1'b1, REG_STATUS, 32'hffff_ffff, rdata, err);
			check("status write error", 32'(err), 32'd1);
			apb_xfer(1'b0, REG_STATUS, 32'd0, rdata, err);
			check("status after write", rdata, 32'd0);
			apb_xfer(1'b0, 12'h010, 32'd0, rdata, err);
			check("unmapped read error", 32'(err), 32'd1);
			apb_xfer(1'b1, 12'h020, 32'h1, rdata, err);
			check("unmapped write error", 32'(err), 32'd1);
			report_test("apb_config");

			apb_xfer(1'b1, REG_CTRL, 32'h3, rdata, err);
			feed_jobs(0, 5, 1'b1);
			wait_words(5);
			report_test("read_cmd_shared");

			apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
			feed_jobs(5, 5, 1'b0);
			wait_words(10);
			report_test("read_cmd_non_alloc");

			// memory blocked until the job queue pushes back
			ready_mode = 2;
			req_mode = 1;
			apb_xfer(1'b1, REG_CTRL, 32'h3, rdata, err);
			fork
				feed_jobs(10, n_rec - 12, 1'b1);
			join_none
			held = 0;
			@(posedge clock);
			#1;
			while (edge_request && held < 100) begin
				@(posedge clock);
				#1;
				held++;
			end
			if (edge_request) begin
				$display("edge_request stayed high while read commands were blocked");
				errors++;
				test_errs++;
			end
			ready_mode = 1;
			wait_words(n_rec - 2);
			ready_mode = 0;
			req_mode = 0;
			repeat (20) @(posedge clock);
			check("words received", 32'(rx_count), 32'(n_rec - 2));
			report_test("back_pressure");

			// last two jobs parked behind a blocked memory, then enable cleared
			ready_mode = 2;
			feed_jobs(n_rec - 2, 2, 1'b1);
			apb_xfer(1'b1, REG_CTRL, 32'h2, rdata, err);
			ready_mode = 0;
			cmds_before = cmd_seen;
			repeat (20) @(posedge clock);
			check("edge_request while disabled", 32'(edge_request), 32'd0);
			check("commands while disabled", 32'(cmd_seen), 32'(cmds_before));
			apb_xfer(1'b1, REG_CTRL, 32'h3, rdata, err);
			wait_words(n_rec);
			report_test("enable");

			apb_xfer(1'b0, REG_STATUS, 32'd0, rdata, err);
			check("status outstanding", 32'(rdata[23:16]), 32'd0);
			check("status pushed", 32'(rdata[15:0]), 32'(n_rec) % DEGREE);
			report_test("status");
		end
		errors += dut.u_control.u_sva.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* design/cu_config_apb.sv */
////////////////////////////////////////
// APB3, no wait states; REG_STATUS is
// read-only, unmapped offsets flag pslverr
////////////////////////////////////////

`timescale 1ns/1ps

module cu_config_apb
	import edge_fetch_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  apb_req_t   apb_req,
	output apb_rsp_t   apb_rsp,
	input  cu_status_t status,
	output cu_config_t cfg
);

	cu_config_t cfg_q;
	logic       access;
	logic       mapped;
	logic       status_hit;
	logic       wr_en;

	assign access     = apb_req.psel & apb_req.penable;
	assign status_hit = (apb_req.paddr == REG_STATUS);
	assign mapped     = (apb_req.paddr == REG_CTRL) | (apb_req.paddr == REG_BASE) |
	                    (apb_req.paddr == REG_DEGREE) | status_hit;
	assign wr_en      = access & apb_req.pwrite & mapped & ~status_hit;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_q <= '0;
		end else if (wr_en) begin
			case (apb_req.paddr)
				REG_CTRL: begin
					cfg_q.enable      <= apb_req.pwdata[0];
					cfg_q.shared_read <= apb_req.pwdata[1];
				end
				REG_BASE:   cfg_q.base   <= apb_req.pwdata;
				REG_DEGREE: cfg_q.degree <= apb_req.pwdata[15:0];
				default:    cfg_q        <= cfg_q;
			endcase
		end
	end

	assign cfg = cfg_q;

////////////////////////////////////////
// read data and response
////////////////////////////////////////

	always_comb begin
		case (apb_req.paddr)
			REG_CTRL:   apb_rsp.prdata = {30'd0, cfg_q.shared_read, cfg_q.enable};
			REG_BASE:   apb_rsp.prdata = cfg_q.base;
			REG_DEGREE: apb_rsp.prdata = {16'd0, cfg_q.degree};
			// outstanding in [23:16], pushed in [15:0]
			REG_STATUS: apb_rsp.prdata = {8'd0, status.outstanding, status.pushed};
			default:    apb_rsp.prdata = '0;
		endcase
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & status_hit));
	end

endmodule

/* design/edge_data_control.sv */
////////////////////////////////////////
// responses must return in command order
// at most FIFO_DEPTH-2 words held in flight
////////////////////////////////////////

`timescale 1ns/1ps

module edge_data_control
	import edge_fetch_pkg::*;
#(
	parameter int CU_ID      = 1,
	parameter int FIFO_DEPTH = 8
) (
	input  logic        clock,
	input  logic        rstn,
	input  cu_config_t  cfg,
	output cu_status_t  status,
	input  edge_job_t   edge_job,
	input  vertex_job_t vertex_job,
	output logic        edge_request,
	output read_cmd_t   read_cmd,
	input  logic        cmd_ready,
	input  logic        read_response,
	input  line_half_t  line_lo,
	input  line_half_t  line_hi,
	input  logic        edge_data_request,
	output edge_data_t  edge_data
);

	localparam int         LINE_WORDS = LINE_BITS / WORD_BITS;
	localparam logic [7:0] READ_LIMIT = 8'(FIFO_DEPTH - 2);

	edge_job_t                  job_in_q;
	edge_job_t                  job_head;
	logic                       job_pop;
	logic                       job_valid;
	logic                       job_almost_full;
	logic                       job_empty;
	read_cmd_t                  cmd_next;
	read_cmd_t                  cmd_head;
	logic                       cmd_pop;
	logic                       cmd_valid;
	logic                       cmd_almost_full;
	logic                       cmd_empty;
	line_half_t                 lo_q;
	line_half_t                 hi_q;
	logic                       line_we;
	logic [WORD_INDEX_BITS-1:0] rd_index_q;
	logic                       rd_pending_q;
	logic                       word_valid_q;
	logic [WORD_BITS-1:0]       ram_word;
	edge_data_t                 edge_next;
	edge_data_t                 edge_head;
	logic                       edge_pop;
	logic                       edge_valid;
	logic                       edge_empty;
	logic [7:0]                 outstanding_q;
	logic [7:0]                 reserved_q;
	logic [15:0]                pushed_q;
	logic [15:0]                pushed_next;
	logic [15:0]                degree;

	function automatic logic [WORD_BITS-1:0] swap_bytes(input logic [WORD_BITS-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

////////////////////////////////////////
// job queue and read command forming
////////////////////////////////////////

	assign edge_request = cfg.enable & ~job_almost_full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			job_in_q <= '0;
		else
			job_in_q <= edge_job;
	end

	// hold jobs back once the read window is used up
	assign job_pop = cfg.enable & ~job_empty & ~cmd_almost_full & (outstanding_q < READ_LIMIT);

	sync_fifo #(.payload_t(edge_job_t), .FIFO_DEPTH(FIFO_DEPTH)) u_job_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (job_in_q.valid),
		.data_in     (job_in_q),
		.pop         (job_pop),
		.data_out    (job_head),
		.valid       (job_valid),
		.full        (),
		.almost_full (job_almost_full),
		.empty       (job_empty)
	);

	always_comb begin
		cmd_next.valid   = 1'b1;
		cmd_next.kind    = cfg.shared_read ? read_cl_s : read_cl_na;
		cmd_next.address = cfg.base + {job_head.dest[29:0], 2'b00};
		cmd_next.size    = 8'(WORD_BITS / 8);
		cmd_next.cu_id   = 4'(CU_ID);
		cmd_next.offset  = job_head.dest[WORD_INDEX_BITS-1:0];
	end

	// issue only while the edge data queue has room for the answer
	assign cmd_pop = cfg.enable & cmd_ready & ~cmd_empty & (reserved_q < READ_LIMIT);

	sync_fifo #(.payload_t(read_cmd_t), .FIFO_DEPTH(FIFO_DEPTH)) u_cmd_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (job_valid),
		.data_in     (cmd_next),
		.pop         (cmd_pop),
		.data_out    (cmd_head),
		.valid       (cmd_valid),
		.full        (),
		.almost_full (cmd_almost_full),
		.empty       (cmd_empty)
	);

	always_comb begin
		read_cmd       = cmd_head;
		read_cmd.valid = cmd_valid;
	end

////////////////////////////////////////
// line path
////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lo_q         <= '0;
			hi_q         <= '0;
			rd_pending_q <= 1'b0;
			word_valid_q <= 1'b0;
		end else begin
			lo_q         <= line_lo;
			hi_q         <= line_hi;
			rd_pending_q <= line_we;
			word_valid_q <= rd_pending_q;
		end
	end

	assign line_we = lo_q.valid & hi_q.valid;

	// word index taken from the echoed offset
	always_ff @(posedge clock) begin
		if (line_we)
			rd_index_q <= lo_q.offset;
	end

	line_word_ram #(.LINE_WORDS(LINE_WORDS)) u_line_ram (
		.clock    (clock),
		.we       (line_we),
		.line_in  ({hi_q.data, lo_q.data}),
		.rd_index (rd_index_q),
		.word_out (ram_word)
	);

	assign edge_next = '{valid: 1'b1, data: swap_bytes(ram_word)};
	assign edge_pop  = cfg.enable & edge_data_request & ~edge_empty;

	sync_fifo #(.payload_t(edge_data_t), .FIFO_DEPTH(FIFO_DEPTH)) u_edge_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (word_valid_q),
		.data_in     (edge_next),
		.pop         (edge_pop),
		.data_out    (edge_head),
		.valid       (edge_valid),
		.full        (),
		.almost_full (),
		.empty       (edge_empty)
	);

	always_comb begin
		edge_data       = edge_head;
		edge_data.valid = edge_valid;
	end

////////////////////////////////////////
// counters
////////////////////////////////////////

	// a vertex job overrides the programmed degree
	assign degree      = vertex_job.valid ? vertex_job.degree : cfg.degree;
	assign pushed_next = pushed_q + 16'd1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding_q <= '0;
			reserved_q    <= '0;
			pushed_q      <= '0;
		end else begin
			case ({cmd_valid, read_response})
				2'b10:   outstanding_q <= outstanding_q + 8'd1;
				2'b01:   outstanding_q <= outstanding_q - 8'd1;
				default: outstanding_q <= outstanding_q;
			endcase
			// from issue until the consumer takes the word
			case ({cmd_pop, edge_pop})
				2'b10:   reserved_q <= reserved_q + 8'd1;
				2'b01:   reserved_q <= reserved_q - 8'd1;
				default: reserved_q <= reserved_q;
			endcase
			if (word_valid_q)
				pushed_q <= (pushed_next == degree) ? 16'd0 : pushed_next;
		end
	end

	assign status = '{outstanding: outstanding_q, pushed: pushed_q};

endmodule

/* design/edge_fetch_pkg.sv */
////////////////////////////////////////
// one compute unit, 32-bit words in 128-bit lines
// two 64-bit halves per returned line
////////////////////////////////////////

package edge_fetch_pkg;

	localparam int WORD_BITS       = 32;
	localparam int LINE_BITS       = 128;
	localparam int HALF_BITS       = 64;
	localparam int WORD_INDEX_BITS = $clog2(LINE_BITS / WORD_BITS);

	// register map, byte offsets
	localparam logic [11:0] REG_CTRL   = 12'h000;
	localparam logic [11:0] REG_BASE   = 12'h004;
	localparam logic [11:0] REG_DEGREE = 12'h008;
	localparam logic [11:0] REG_STATUS = 12'h00C;

	// cacheline read encodings on the command bus
	typedef enum logic [12:0] {
		read_cl_s  = 13'h0A50,
		read_cl_na = 13'h0A00
	} read_cmd_kind_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] dest;
		logic [31:0] src;
	} edge_job_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] degree;
	} vertex_job_t;

	typedef struct packed {
		logic                       valid;
		read_cmd_kind_t             kind;
		logic [31:0]                address;
		logic [7:0]                 size;
		logic [3:0]                 cu_id;
		logic [WORD_INDEX_BITS-1:0] offset;
	} read_cmd_t;

	typedef struct packed {
		logic                       valid;
		logic [WORD_INDEX_BITS-1:0] offset;
		logic [HALF_BITS-1:0]       data;
	} line_half_t;

	typedef struct packed {
		logic                 valid;
		logic [WORD_BITS-1:0] data;
	} edge_data_t;

	typedef struct packed {
		logic        enable;
		logic        shared_read;
		logic [31:0] base;
		logic [15:0] degree;
	} cu_config_t;

	typedef struct packed {
		logic [7:0]  outstanding;
		logic [15:0] pushed;
	} cu_status_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

/* design/edge_fetch_top.sv */
////////////////////////////////////////
// one compute-unit slice, FIFO_DEPTH is
// a power of two, 4 or more
////////////////////////////////////////

`timescale 1ns/1ps

module edge_fetch_top
	import edge_fetch_pkg::*;
#(
	parameter int CU_ID      = 1,
	parameter int FIFO_DEPTH = 8
) (
	input  logic        clock,
	input  logic        rstn,
	input  apb_req_t    apb_req,
	output apb_rsp_t    apb_rsp,
	input  edge_job_t   edge_job,
	input  vertex_job_t vertex_job,
	output logic        edge_request,
	output read_cmd_t   read_cmd,
	input  logic        cmd_ready,
	input  logic        read_response,
	input  line_half_t  line_lo,
	input  line_half_t  line_hi,
	input  logic        edge_data_request,
	output edge_data_t  edge_data
);

	cu_config_t cfg;
	cu_status_t status;

	// configuration and status registers
	cu_config_apb u_config (
		.clock   (clock),
		.rstn    (rstn),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.status  (status),
		.cfg     (cfg)
	);

	// job to command to edge data path
	edge_data_control #(
		.CU_ID      (CU_ID),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_control (
		.clock             (clock),
		.rstn              (rstn),
		.cfg               (cfg),
		.status            (status),
		.edge_job          (edge_job),
		.vertex_job        (vertex_job),
		.edge_request      (edge_request),
		.read_cmd          (read_cmd),
		.cmd_ready         (cmd_ready),
		.read_response     (read_response),
		.line_lo           (line_lo),
		.line_hi           (line_hi),
		.edge_data_request (edge_data_request),
		.edge_data         (edge_data)
	);

endmodule

/* design/line_word_ram.sv */
////////////////////////////////////////
// single line, written whole; word read
// has one cycle of latency
////////////////////////////////////////

`timescale 1ns/1ps

module line_word_ram
	import edge_fetch_pkg::*;
#(
	parameter int LINE_WORDS = LINE_BITS / WORD_BITS
) (
	input  logic                          clock,
	input  logic                          we,
	input  logic [LINE_BITS-1:0]          line_in,
	input  logic [$clog2(LINE_WORDS)-1:0] rd_index,
	output logic [WORD_BITS-1:0]          word_out
);

	// word 0 sits in the low bits of the line
	logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_q;

	always_ff @(posedge clock) begin
		if (we)
			line_q <= line_in;
	end

	always_ff @(posedge clock) begin
		word_out <= line_q[rd_index];
	end

endmodule

/* design/sync_fifo.sv */
////////////////////////////////////////
// depth must be a power of two, 4 or more
////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t  = logic [31:0],
	parameter int  FIFO_DEPTH = 8
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     valid,
	output logic     full,
	output logic     almost_full,
	output logic     empty
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	payload_t            mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	assign do_push     = push & ~full;
	assign do_pop      = pop & ~empty;
	assign full        = (count == (PTR_BITS + 1)'(FIFO_DEPTH));
	assign almost_full = (count >= (PTR_BITS + 1)'(FIFO_DEPTH - 2));
	assign empty       = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + PTR_BITS'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + PTR_BITS'(1);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			valid <= do_pop;
		end
	end

	// storage and head register
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

endmodule

/* flist.f */
design/edge_fetch_pkg.sv
design/sync_fifo.sv
design/line_word_ram.sv
design/edge_data_control.sv
design/cu_config_apb.sv
design/edge_fetch_top.sv
bench/edge_fetch_sva.sv
bench/tb_edge_fetch.sv
